//--- compile.f
rtl/sd_host_pkg.sv
rtl/sd_proto_pkg.sv
rtl/sd_read_if.sv
rtl/spi_byte_if.sv
rtl/sd_spi_shifter.sv
rtl/sd_reader.sv
rtl/sdcard.sv
bench/sdcard_asserts.sv
bench/sd_card_model.sv
bench/tb_sdcard.sv

//--- Bender.yml
package:
  name: sdcard

sources:
  - files:
      - rtl/sd_host_pkg.sv
      - rtl/sd_proto_pkg.sv
      - rtl/sd_read_if.sv
      - rtl/spi_byte_if.sv
      - rtl/sd_spi_shifter.sv
      - rtl/sd_reader.sv
      - rtl/sdcard.sv
  - target: test
    files:
      - bench/sdcard_asserts.sv
      - bench/sd_card_model.sv
      - bench/tb_sdcard.sv

//--- bench/tb_sdcard.sv
/*
 * testbench for the sd card host block
 * runs a table of sector reads against a behavioral sdhc card
 */
`timescale 1ns/1ps
`default_nettype none

module tb_sdcard
  import sd_host_pkg::*;
();

  localparam int unsigned ClockDiv = 2;
  localparam int unsigned NumEntries = 5;
  // one spi byte is 16 divided half periods
  localparam int unsigned ByteCycles = 16 * ClockDiv;
  localparam int unsigned TimeoutCycles = NumEntries * 600 * ByteCycles + 40 * ByteCycles;

  typedef struct {
    logic [31:0] sector;
    int unsigned steps;
  } read_entry_t;

  logic         clk;
  logic         rst_n;
  sd_host_cmd_e cmd;
  logic [31:0]  sector_addr;
  sd_byte_t     data;
  logic         busy;
  logic [3:0]   card_stat;
  card_type_e   card_type;
  logic         sd_clk;
  logic         sd_cs_n;
  logic         sd_mosi;
  logic         sd_miso;
  logic [31:0]  exp_sector;
  logic         bad_arg;
  read_entry_t  read_table [NumEntries];
  integer       seed;
  int unsigned  cycle_cnt;
  int unsigned  i;

  sdcard #(
    .ClockDivider(ClockDiv)
  ) dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_i           (cmd),
    .sector_address_i(sector_addr),
    .data_o          (data),
    .busy_o          (busy),
    .card_stat_o     (card_stat),
    .card_type_o     (card_type),
    .sd_clk_o        (sd_clk),
    .sd_cs_n_o       (sd_cs_n),
    .sd_mosi_o       (sd_mosi),
    .sd_miso_i       (sd_miso)
  );

  sd_card_model u_card (
    .sd_clk_i    (sd_clk),
    .sd_cs_n_i   (sd_cs_n),
    .sd_mosi_i   (sd_mosi),
    .sd_miso_o   (sd_miso),
    .exp_sector_i(exp_sector),
    .bad_arg_o   (bad_arg)
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first failed check");
  endtask

  // timeout and assertion watch
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: the DUT did not finish within %0d clock cycles", TimeoutCycles);
      stop_with_failure();
    end else if (dut.u_asserts.fail_cnt != 0) begin
      $display("an assertion on the DUT handshake failed at %0t", $time);
      stop_with_failure();
    end
  end

  // byte n of sector s, n wraps at the sector size
  function automatic sd_byte_t expected_byte(input logic [31:0] s, input int unsigned n);
    int unsigned k;
    k = n % SectorBytes;
    return s[7:0] + k[7:0];
  endfunction

  task automatic check_byte(input string name, input sd_byte_t act, input sd_byte_t exp);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s: got %02h, expected %02h", $time, name, act, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_card_type(input card_type_e act, input card_type_e exp);
    if (act !== exp) begin
      $display("[FAIL] t=%0t card_type_o: got %s, expected %s", $time, act.name(), exp.name());
      stop_with_failure();
    end
  endtask

  task automatic check_busy(input logic act, input logic exp);
    if (act !== exp) begin
      $display("[FAIL] t=%0t busy_o: got %b, expected %b", $time, act, exp);
      stop_with_failure();
    end
  endtask

  // inputs change shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic wait_not_busy();
    while (busy !== 1'b0) next_cycle();
  endtask

  task automatic run_read(input read_entry_t e);
    int unsigned n;
    exp_sector  = e.sector;
    sector_addr = e.sector;
    cmd         = HostRead;
    next_cycle();
    check_busy(busy, 1'b1);
    // requests while busy must not disturb the running read
    sector_addr = ~e.sector;
    next_cycle();
    cmd = HostNext;
    repeat (3) next_cycle();
    cmd = HostIdle;
    wait_not_busy();
    if (bad_arg) begin
      $display("the card saw a CMD17 argument other than sector %08h", e.sector);
      stop_with_failure();
    end
    check_byte("data_o (step 0)", data, expected_byte(e.sector, 0));
    cmd = HostNext;
    for (n = 1; n <= e.steps; n++) begin
      next_cycle();
      check_byte($sformatf("data_o (step %0d)", n), data, expected_byte(e.sector, n));
    end
    cmd = HostIdle;
    next_cycle();
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd         = HostIdle;
    sector_addr = '0;
    exp_sector  = '0;
    cycle_cnt   = 0;
    seed        = 32'h2cfb;
    // sector and number of steps; 512 steps show the wrap
    read_table[0] = '{32'h0000_0000, 3};
    read_table[1] = '{32'h0000_0005, 512};
    read_table[2] = '{32'h0001_00A7, 40};
    read_table[3] = '{32'h0000_0000, 20};
    read_table[3].sector = $random(seed);
    read_table[4] = '{32'hFFFF_FF10, 2};
    repeat (8) next_cycle();
    rst_n = 1'b1;
    check_busy(busy, 1'b1);
    wait_not_busy();
    check_card_type(card_type, CardSdhc);
    for (i = 0; i < NumEntries; i++) begin
      run_read(read_table[i]);
    end
    if (dut.u_asserts.fail_cnt != 0) begin
      $display("%0d assertion failures on the DUT handshake", dut.u_asserts.fail_cnt);
      stop_with_failure();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- bench/sd_card_model.sv
/*
 * behavioral sdhc card in spi mode
 * answers the init sequence and cmd17 with a patterned sector
 */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model
  import sd_host_pkg::*, sd_proto_pkg::*;
(
  input  logic        sd_clk_i,
  input  logic        sd_cs_n_i,
  input  logic        sd_mosi_i,
  output logic        sd_miso_o,
  // sector the bench expects on the next cmd17
  input  logic [31:0] exp_sector_i,
  // sticky, set when a cmd17 argument is not the expected sector
  output logic        bad_arg_o
);

  logic [7:0]  rx_sh;
  logic [7:0]  tx_sh;
  logic [47:0] frame;
  logic [7:0]  out_q [$];
  int unsigned bit_cnt;
  int unsigned frame_cnt;
  int unsigned acmd41_cnt;
  logic        ready;

  initial begin
    rx_sh      = 8'hFF;
    tx_sh      = 8'hFF;
    frame      = '0;
    bit_cnt    = 0;
    frame_cnt  = 0;
    acmd41_cnt = 0;
    ready      = 1'b0;
    bad_arg_o  = 1'b0;
  end

  // line idles high while deselected
  assign sd_miso_o = sd_cs_n_i ? 1'b1 : tx_sh[7];

  // queue the answer bytes of one command
  task automatic answer(input logic [5:0] idx, input logic [31:0] arg);
    int unsigned k;
    case (idx)
      CmdGoIdle: out_q.push_back(R1Idle);
      CmdSendIfCond: begin
        // r7 echoes voltage range and check pattern
        out_q.push_back(R1Idle);
        out_q.push_back(8'h00);
        out_q.push_back(8'h00);
        out_q.push_back({4'h0, arg[11:8]});
        out_q.push_back(arg[7:0]);
      end
      CmdAppCmd: out_q.push_back(ready ? 8'h00 : R1Idle);
      AcmdSendOpCond: begin
        // first acmd41 still busy, so the retry loop runs once
        if (acmd41_cnt == 0) begin
          out_q.push_back(R1Idle);
        end else begin
          out_q.push_back(8'h00);
          ready = 1'b1;
        end
        acmd41_cnt++;
      end
      CmdReadOcr: begin
        // ocr with power up done and ccs set
        out_q.push_back(8'h00);
        out_q.push_back(8'hC0);
        out_q.push_back(8'hFF);
        out_q.push_back(8'h80);
        out_q.push_back(8'h00);
      end
      CmdReadSingle: begin
        if (arg !== exp_sector_i) bad_arg_o = 1'b1;
        out_q.push_back(8'h00);
        // a short access delay before the token
        out_q.push_back(8'hFF);
        out_q.push_back(8'hFF);
        out_q.push_back(DataStartToken);
        for (k = 0; k < SectorBytes; k++) begin
          out_q.push_back(arg[7:0] + k[7:0]);
        end
        out_q.push_back(8'h3C);
        out_q.push_back(8'hC3);
      end
      // illegal command
      default: out_q.push_back(8'h04);
    endcase
  endtask

  // collect six byte frames, filler bytes between frames are skipped
  task automatic take_byte(input logic [7:0] b);
    if (frame_cnt != 0 || b[7:6] == 2'b01) begin
      frame = {frame[39:0], b};
      frame_cnt++;
      if (frame_cnt == 6) begin
        frame_cnt = 0;
        answer(frame[45:40], frame[39:8]);
      end
    end
  endtask

  // deselect ends any frame and drops pending answers
  always @(posedge sd_cs_n_i) begin
    bit_cnt   = 0;
    frame_cnt = 0;
    tx_sh     = 8'hFF;
    out_q.delete();
  end

  // mosi sampled on rising edges, msb first
  always @(posedge sd_clk_i) begin
    if (!sd_cs_n_i) begin
      rx_sh   = {rx_sh[6:0], sd_mosi_i};
      bit_cnt = (bit_cnt + 1) % 8;
      if (bit_cnt == 0) take_byte(rx_sh);
    end
  end

  // miso changes on falling edges, next byte loaded after the eighth bit
  always @(negedge sd_clk_i) begin
    if (!sd_cs_n_i) begin
      if (bit_cnt != 0) begin
        tx_sh = {tx_sh[6:0], 1'b1};
      end else if (out_q.size() > 0) begin
        tx_sh = out_q.pop_front();
      end else begin
        tx_sh = 8'hFF;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/sdcard_asserts.sv
/*
 * concurrent checks on the host handshake of the sd card block
 */
`timescale 1ns/1ps
`default_nettype none

module sdcard_asserts
  import sd_host_pkg::*, sd_proto_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  input sd_host_cmd_e cmd_i,
  input logic         busy_o,
  input logic         sd_cs_n_o,
  input logic [3:0]   card_stat_o
);

  // counts failed assertions, watched by the bench
  int unsigned fail_cnt = 0;

  busy_known_a: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(busy_o))
    else begin
      $error("busy_o is unknown");
      fail_cnt = fail_cnt + 1;
    end

  // idle read request raises busy on the next edge
  read_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!busy_o && cmd_i == HostRead) |=> busy_o)
    else begin
      $error("busy_o did not rise after a read request");
      fail_cnt = fail_cnt + 1;
    end

  // card is deselected whenever the host side is idle
  idle_cs_a: assert property (@(posedge clk) disable iff (!rst_n) !busy_o |-> sd_cs_n_o)
    else begin
      $error("card selected while busy_o is low");
      fail_cnt = fail_cnt + 1;
    end

  idle_state_a: assert property (@(posedge clk) disable iff (!rst_n)
    !busy_o |-> card_stat_o == RdReady)
    else begin
      $error("reader not in its ready state while busy_o is low");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind sdcard sdcard_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_i      (cmd_i),
  .busy_o     (busy_o),
  .sd_cs_n_o  (sd_cs_n_o),
  .card_stat_o(card_stat_o)
);

`default_nettype wire

//--- rtl/sdcard.sv
/*
 * sd card host block
 * decodes host commands, buffers one sector and serves it byte by byte
 */
`timescale 1ns/1ps
`default_nettype none

module sdcard
  import sd_host_pkg::*;
#(
  parameter int unsigned ClockDivider = 2
) (
  input  logic         clk,
  input  logic         rst_n,
  input  sd_host_cmd_e cmd_i,
  input  logic [31:0]  sector_address_i,
  output sd_byte_t     data_o,
  output logic         busy_o,
  output logic [3:0]   card_stat_o,
  output card_type_e   card_type_o,
  output logic         sd_clk_o,
  output logic         sd_cs_n_o,
  output logic         sd_mosi_o,
  input  logic         sd_miso_i
);

  typedef enum logic [1:0] {
    Init,
    Idle,
    ReadSector
  } top_state_e;

  top_state_e             state_q;
  sd_byte_t               buffer_q [SectorBytes];
  logic [SectorAddrW-1:0] idx_q;
  logic                   rstart_q;
  logic [31:0]            rsector_q;

  sd_read_if rd_if ();

  assign rd_if.rstart  = rstart_q;
  assign rd_if.rsector = rsector_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= Init;
      idx_q    <= '0;
      rstart_q <= 1'b0;
      busy_o   <= 1'b1;
    end else begin
      rstart_q <= 1'b0;
      case (state_q)
        Init: begin
          // card init runs straight out of reset
          if (!rd_if.rbusy) begin
            busy_o  <= 1'b0;
            state_q <= Idle;
          end
        end
        Idle: begin
          if (cmd_i == HostRead) begin
            rsector_q <= sector_address_i;
            rstart_q  <= 1'b1;
            idx_q     <= '0;
            busy_o    <= 1'b1;
            state_q   <= ReadSector;
          end else if (cmd_i == HostNext) begin
            idx_q <= idx_q + 1'b1;
          end
        end
        default: begin
          if (rd_if.outen) idx_q <= idx_q + 1'b1;
          // index has wrapped back to 0 by now
          if (rd_if.rdone) begin
            busy_o  <= 1'b0;
            state_q <= Idle;
          end
        end
      endcase
    end
  end

  // sector buffer
  always_ff @(posedge clk) begin
    if (state_q == ReadSector && rd_if.outen) buffer_q[idx_q] <= rd_if.outbyte;
  end

  assign data_o = buffer_q[idx_q];

  sd_reader #(
    .ClockDivider(ClockDivider)
  ) u_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd_if.reader),
    .sd_clk_o   (sd_clk_o),
    .sd_cs_n_o  (sd_cs_n_o),
    .sd_mosi_o  (sd_mosi_o),
    .sd_miso_i  (sd_miso_i),
    .card_stat_o(card_stat_o),
    .card_type_o(card_type_o)
  );

endmodule

`default_nettype wire

//--- rtl/sd_reader.sv
/*
 * sd card reader in spi mode
 * runs card init and single block reads, streams the sector bytes out
 */
`timescale 1ns/1ps
`default_nettype none

module sd_reader
  import sd_host_pkg::*, sd_proto_pkg::*;
#(
  parameter int unsigned ClockDivider = 2
) (
  input  logic          clk,
  input  logic          rst_n,
  sd_read_if.reader     rd,
  output logic          sd_clk_o,
  output logic          sd_cs_n_o,
  output logic          sd_mosi_o,
  input  logic          sd_miso_i,
  output logic [3:0]    card_stat_o,
  output card_type_e    card_type_o
);

  reader_state_e          state_q;
  sd_cmd_idx_e            cmd_q;
  logic [47:0]            frame_q;
  logic [SectorAddrW-1:0] cnt_q;
  logic [23:0]            resp_q;
  card_type_e             type_q;
  logic                   cs_n_q;
  logic                   wait_q;
  logic                   start_q;
  sd_byte_t               tx_q;
  logic                   rbusy_q;
  logic                   rdone_q;
  logic                   outen_q;
  sd_byte_t               outbyte_q;
  logic                   issue;
  sd_cmd_idx_e            issue_idx;
  logic [31:0]            issue_arg;
  sd_byte_t               issue_crc;
  sd_byte_t               rx;

  spi_byte_if spi_if ();

  sd_spi_shifter #(
    .ClockDivider(ClockDivider)
  ) u_shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi      (spi_if.phy),
    .sd_clk_o (sd_clk_o),
    .sd_mosi_o(sd_mosi_o),
    .sd_miso_i(sd_miso_i)
  );

  assign spi_if.start   = start_q;
  assign spi_if.tx_byte = tx_q;
  assign rx             = spi_if.rx_byte;

  // six byte frame, start bits, index, argument, crc with end bit
  function automatic logic [47:0] cmd_frame(input sd_cmd_idx_e idx, input logic [31:0] arg,
                                            input sd_byte_t crc);
    return {2'b01, idx, arg, crc};
  endfunction

  // where to go when a command gets no r1 in time
  function automatic reader_state_e retry_state(input sd_cmd_idx_e idx);
    case (idx)
      CmdGoIdle:     return RdCmd0;
      CmdReadOcr:    return RdCmd58;
      CmdReadSingle: return RdCmd17;
      // cmd8 silence leaves the type unknown and goes on with acmd41
      default:       return RdCmd55;
    endcase
  endfunction

  // command issued by each issue state
  always_comb begin
    issue     = 1'b1;
    issue_idx = CmdGoIdle;
    issue_arg = '0;
    issue_crc = 8'hFF;
    case (state_q)
      RdCmd0:   issue_crc = Cmd0Crc;
      RdCmd8: begin
        issue_idx = CmdSendIfCond;
        issue_arg = IfCondArg;
        issue_crc = Cmd8Crc;
      end
      RdCmd55:  issue_idx = CmdAppCmd;
      RdAcmd41: begin
        issue_idx = AcmdSendOpCond;
        issue_arg = Acmd41Arg;
      end
      RdCmd58:  issue_idx = CmdReadOcr;
      RdCmd17: begin
        issue_idx = CmdReadSingle;
        // sdhc takes block numbers, older cards take byte addresses
        issue_arg = (type_q == CardSdhc) ? rd.rsector : {rd.rsector[22:0], 9'd0};
      end
      default:  issue = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= RdPowerUp;
      cmd_q   <= CmdGoIdle;
      cnt_q   <= '0;
      type_q  <= CardUnknown;
      cs_n_q  <= 1'b1;
      wait_q  <= 1'b0;
      start_q <= 1'b0;
      rbusy_q <= 1'b1;
      rdone_q <= 1'b0;
      outen_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      rdone_q <= 1'b0;
      outen_q <= 1'b0;
      if (issue) begin
        frame_q <= cmd_frame(issue_idx, issue_arg, issue_crc);
        cmd_q   <= issue_idx;
        cnt_q   <= '0;
        cs_n_q  <= 1'b0;
        state_q <= RdSend;
      end else if (state_q == RdReady) begin
        if (rd.rstart) begin
          rbusy_q <= 1'b1;
          state_q <= RdCmd17;
        end
      end else if (!wait_q) begin
        // every other state moves one byte, 0xff unless a frame is going out
        start_q <= 1'b1;
        wait_q  <= 1'b1;
        tx_q    <= (state_q == RdSend) ? frame_q[47:40] : 8'hFF;
      end else if (spi_if.done) begin
        wait_q <= 1'b0;
        cnt_q  <= cnt_q + 1'b1;
        case (state_q)
          RdPowerUp: if (cnt_q == SectorAddrW'(PowerUpBytes - 1)) state_q <= RdCmd0;
          RdSend: begin
            frame_q <= {frame_q[39:0], 8'hFF};
            if (cnt_q == SectorAddrW'(5)) begin
              cnt_q   <= '0;
              state_q <= RdResp;
            end
          end
          RdResp: begin
            // r1 has its msb clear
            if (!rx[7]) begin
              cnt_q <= '0;
              case (cmd_q)
                CmdGoIdle: begin
                  cs_n_q  <= 1'b1;
                  state_q <= (rx == R1Idle) ? RdCmd8 : RdCmd0;
                end
                CmdSendIfCond: begin
                  // illegal command bit set on v1 cards
                  if (rx[2]) begin
                    cs_n_q  <= 1'b1;
                    state_q <= RdCmd55;
                  end else begin
                    state_q <= RdTail;
                  end
                end
                CmdAppCmd: begin
                  cs_n_q  <= 1'b1;
                  state_q <= RdAcmd41;
                end
                AcmdSendOpCond: begin
                  cs_n_q  <= 1'b1;
                  state_q <= (rx == 8'h00) ? RdCmd58 : RdCmd55;
                end
                CmdReadOcr: state_q <= RdTail;
                default: begin
                  if (rx == 8'h00) begin
                    state_q <= RdToken;
                  end else begin
                    cs_n_q  <= 1'b1;
                    state_q <= RdCmd17;
                  end
                end
              endcase
            end else if (cnt_q == SectorAddrW'(RespWaitBytes - 1)) begin
              cs_n_q  <= 1'b1;
              state_q <= retry_state(cmd_q);
            end
          end
          RdTail: begin
            // four trailing bytes of r7 or r3
            resp_q <= {resp_q[15:0], rx};
            if (cnt_q == SectorAddrW'(3)) begin
              cs_n_q <= 1'b1;
              if (cmd_q == CmdSendIfCond) begin
                // voltage accepted and check pattern echoed
                if (resp_q[3:0] == 4'h1 && rx == IfCondArg[7:0]) type_q <= CardSdV2;
                state_q <= RdCmd55;
              end else begin
                // ccs is ocr bit 30
                if (type_q == CardSdV2 && resp_q[22]) type_q <= CardSdhc;
                rbusy_q <= 1'b0;
                state_q <= RdReady;
              end
            end
          end
          RdToken: begin
            if (rx == DataStartToken) begin
              cnt_q   <= '0;
              state_q <= RdData;
            end
          end
          RdData: begin
            outen_q   <= 1'b1;
            outbyte_q <= rx;
            if (cnt_q == SectorAddrW'(SectorBytes - 1)) begin
              cnt_q   <= '0;
              state_q <= RdCrc;
            end
          end
          RdCrc: begin
            // data crc is read and dropped
            if (cnt_q == SectorAddrW'(1)) begin
              cs_n_q  <= 1'b1;
              rdone_q <= 1'b1;
              rbusy_q <= 1'b0;
              state_q <= RdReady;
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign rd.rbusy    = rbusy_q;
  assign rd.rdone    = rdone_q;
  assign rd.outen    = outen_q;
  assign rd.outbyte  = outbyte_q;
  assign sd_cs_n_o   = cs_n_q;
  assign card_stat_o = state_q;
  assign card_type_o = type_q;

endmodule

`default_nettype wire

//--- rtl/sd_spi_shifter.sv
/*
 * spi byte shifter, mode 0, msb first
 * divides clk down to the spi bit clock and moves one byte per request
 */
`timescale 1ns/1ps
`default_nettype none

module sd_spi_shifter
  import sd_host_pkg::*;
#(
  parameter int unsigned ClockDivider = 2
) (
  input  logic    clk,
  input  logic    rst_n,
  spi_byte_if.phy spi,
  output logic    sd_clk_o,
  output logic    sd_mosi_o,
  input  logic    sd_miso_i
);

  localparam int unsigned DivW = (ClockDivider > 1) ? $clog2(ClockDivider) : 1;
  localparam logic [DivW-1:0] DivLast = DivW'(ClockDivider - 1);

  logic            busy_q;
  logic [DivW-1:0] div_q;
  logic [2:0]      bit_q;
  logic            sclk_q;
  logic            mosi_q;
  logic            done_q;
  sd_byte_t        tx_q;
  sd_byte_t        rx_q;
  logic            half_end;

  // last clk cycle of a half period
  assign half_end = busy_q && (div_q == DivLast);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
      sclk_q <= 1'b0;
      mosi_q <= 1'b1;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        if (spi.start) begin
          busy_q <= 1'b1;
          div_q  <= '0;
          bit_q  <= '0;
          // first bit set up before the first rising edge
          mosi_q <= spi.tx_byte[7];
        end
      end else if (half_end) begin
        div_q  <= '0;
        sclk_q <= ~sclk_q;
        // falling edge ends a bit
        if (sclk_q) begin
          if (bit_q == 3'd7) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
            mosi_q <= 1'b1;
          end else begin
            bit_q  <= bit_q + 1'b1;
            mosi_q <= tx_q[6];
          end
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  // data shift registers
  always_ff @(posedge clk) begin
    if (!busy_q && spi.start) begin
      tx_q <= spi.tx_byte;
    end else if (half_end) begin
      if (sclk_q) begin
        tx_q <= {tx_q[6:0], 1'b1};
      end else begin
        // miso sampled on the rising edge
        rx_q <= {rx_q[6:0], sd_miso_i};
      end
    end
  end

  assign sd_clk_o    = sclk_q;
  assign sd_mosi_o   = mosi_q;
  assign spi.rx_byte = rx_q;
  assign spi.done    = done_q;

endmodule

`default_nettype wire

//--- rtl/spi_byte_if.sv
/*
 * one byte spi transfer request and result
 */
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if
  import sd_host_pkg::*;
();

  logic     start;
  sd_byte_t tx_byte;
  // valid in the cycle done is high
  sd_byte_t rx_byte;
  logic     done;

  modport master (output start, tx_byte, input rx_byte, done);
  modport phy (input start, tx_byte, output rx_byte, done);

endinterface

`default_nettype wire

//--- rtl/sd_read_if.sv
/*
 * sector read channel between the host block and the card reader
 */
`timescale 1ns/1ps
`default_nettype none

interface sd_read_if
  import sd_host_pkg::*;
();

  // one cycle pulse, only while rbusy is low
  logic        rstart;
  // sector number, held while busy
  logic [31:0] rsector;
  logic        rbusy;
  // one cycle pulse as rbusy falls
  logic        rdone;
  // a sector byte is on outbyte this cycle
  logic        outen;
  sd_byte_t    outbyte;

  modport host (output rstart, rsector, input rbusy, rdone, outen, outbyte);
  modport reader (input rstart, rsector, output rbusy, rdone, outen, outbyte);

endinterface

`default_nettype wire

//--- rtl/sd_proto_pkg.sv
/*
 * sd spi protocol package
 * command indexes, tokens, fixed arguments and sequencer states
 */
`default_nettype none

package sd_proto_pkg;

  // command indexes used in spi mode
  typedef enum logic [5:0] {
    CmdGoIdle      = 6'd0,
    CmdSendIfCond  = 6'd8,
    CmdReadSingle  = 6'd17,
    AcmdSendOpCond = 6'd41,
    CmdAppCmd      = 6'd55,
    CmdReadOcr     = 6'd58
  } sd_cmd_idx_e;

  localparam logic [7:0] DataStartToken = 8'hFE;
  localparam logic [7:0] R1Idle = 8'h01;
  // dummy bytes with cs high before cmd0
  localparam int PowerUpBytes = 10;
  // polls before a command is given up and resent
  localparam int RespWaitBytes = 16;

  // cmd8 asks for 2.7-3.6 V with check pattern aa
  localparam logic [31:0] IfCondArg = 32'h0000_01AA;
  // acmd41 with hcs set
  localparam logic [31:0] Acmd41Arg = 32'h4000_0000;
  // only cmd0 and cmd8 need a valid crc in spi mode
  localparam logic [7:0] Cmd0Crc = 8'h95;
  localparam logic [7:0] Cmd8Crc = 8'h87;

  // reader sequencer state, also shown on card_stat_o
  typedef enum logic [3:0] {
    RdPowerUp, RdCmd0, RdCmd8, RdCmd55, RdAcmd41, RdCmd58, RdSend,
    RdResp, RdTail, RdReady, RdCmd17, RdToken, RdData, RdCrc
  } reader_state_e;

endpackage

`default_nettype wire

//--- rtl/sd_host_pkg.sv
/*
 * sd host package
 * host command encoding, card type and sector buffer constants
 */
`default_nettype none

package sd_host_pkg;

  // one sector of card data
  localparam int SectorBytes = 512;
  // byte index width inside a sector
  localparam int SectorAddrW = $clog2(SectorBytes);

  // one data byte as seen by the host
  typedef logic [7:0] sd_byte_t;

  // host command on cmd_i
  typedef enum logic [1:0] {
    // nothing to do
    HostIdle = 2'd0,
    // read the sector at sector_address_i
    HostRead = 2'd1,
    // step to the next buffered byte
    HostNext = 2'd2
  } sd_host_cmd_e;

  // card type found during init
  typedef enum logic [1:0] {
    CardUnknown = 2'd0,
    CardSdV1    = 2'd1,
    CardSdV2    = 2'd2,
    CardSdhc    = 2'd3
  } card_type_e;

endpackage

`default_nettype wire
